// ==== tb.f ====
rtl/uart_pkg.sv
rtl/byte_fifo.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_periph.sv
sim/uart_checker.sv
sim/tb_uart.sv

// ==== Makefile ====
SIM   = verilator
FLAGS = --binary --timing --assert
TOP   = tb_uart
FLIST = tb.f
OBJ   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ)

// ==== sim/tb_uart.sv ====
// Divider drops to 4 early on; the first TX bit tick still runs on the reset divider.
`default_nettype none

module tb_uart import uart_pkg::*; ();
    // Bit period after the divider step.
    localparam int TB_DIV  = 4;
    // Echo, burst and two driven frames.
    localparam int N_BYTES = 8 + TX_DEPTH + 2 + 2;
    // First tick at the reset divider, two frame times per byte, slack.
    localparam int TIMEOUT = int'(INIT_DIV) + N_BYTES * 10 * TB_DIV * 2 + 500;
    localparam int N_STEPS = 20;
    // Table operations.
    localparam logic [3:0] OP_PINS  = 4'd0;
    localparam logic [3:0] OP_READ  = 4'd1;
    localparam logic [3:0] OP_WRITE = 4'd2;
    localparam logic [3:0] OP_LOOP  = 4'd3;
    localparam logic [3:0] OP_ECHO  = 4'd4;
    localparam logic [3:0] OP_BURST = 4'd5;
    localparam logic [3:0] OP_RECV  = 4'd6;
    localparam logic [3:0] OP_FRAME = 4'd7;
    // STATUS when both FIFOs are empty and both engines idle.
    localparam logic [31:0] ROOM = (32'h1 << ST_TX_ROOM) | (32'h1 << ST_RX_ROOM);

    typedef struct packed {
        logic [3:0]        op;
        logic [BUS_AW-1:0] addr;
        logic [31:0]       wdat;
        logic [31:0]       exp;
        logic [31:0]       mask;
    } step_t;

    logic              clk;
    logic              rst;
    logic [BUS_AW-1:0] addr;
    logic [3:0]        we;
    logic              re;
    logic [31:0]       wdata;
    wire  [31:0]       rdata;
    wire               ready;
    wire               txd;
    wire               tx_empty;
    wire               rx_full;
    // Line driven here when loopback is off.
    logic              tb_rxd;
    logic              loopback;
    // Expect port to the checker.
    logic              exp_on;
    logic [31:0]       exp_data;
    logic [31:0]       exp_mask;
    logic              pin_on;
    logic [2:0]        exp_pins;
    logic [2:0]        pin_mask;
    int                checks;
    int                errors;
    int                other_errors;
    int                cycles;
    logic [15:0]       lfsr;
    // Bytes in flight, oldest first.
    logic [7:0]        exp_q[$];
    step_t             steps[N_STEPS];

    uart_periph UUT (
        .clk(clk), .rst(rst), .addr(addr), .we(we), .re(re), .wdata(wdata),
        .rdata(rdata), .ready(ready), .txd(txd), .rxd(loopback ? txd : tb_rxd),
        .tx_empty(tx_empty), .rx_full(rx_full)
    );

    uart_checker u_chk (
        .clk(clk), .rst(rst), .ready(ready), .rdata(rdata), .txd(txd),
        .tx_empty(tx_empty), .rx_full(rx_full), .exp_on(exp_on), .exp_data(exp_data),
        .exp_mask(exp_mask), .pin_on(pin_on), .exp_pins(exp_pins),
        .pin_mask(pin_mask), .checks(checks), .errors(errors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Galois step, taps for x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hb400 : 16'h0000);
    endfunction

    // One step per payload bit, LSB first.
    task automatic take_byte(output logic [7:0] b);
        b = '0;
        repeat (8) begin
            b    = {lfsr[0], b[7:1]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Starts and ends on a falling edge.
    task automatic bus_access(input logic [BUS_AW-1:0] a, input logic [3:0] strobes,
                              input logic [31:0] d, output logic [31:0] q,
                              output int waits);
        addr  = a;
        we    = strobes;
        re    = (strobes == 4'h0);
        wdata = d;
        waits = 0;
        do begin
            @(negedge clk);
            waits++;
        end while (!ready);
        q  = rdata;
        we = 4'h0;
        re = 1'b0;
        // Checker samples this response on the next rising edge.
        @(negedge clk);
        exp_on = 1'b0;
    endtask

    // 8N1 frame at TB_DIV cycles per bit.
    task automatic drive_frame(input logic [7:0] b, input logic stop);
        logic [9:0] bits;
        bits = {stop, b, 1'b0};
        repeat (10) begin
            tb_rxd = bits[0];
            bits   = bits >> 1;
            repeat (TB_DIV) @(negedge clk);
        end
        // Long enough idle for a false restart to give up.
        tb_rxd = 1'b1;
        repeat (2 * TB_DIV) @(negedge clk);
    endtask

    // Poll for a byte, then pop it and compare.
    task automatic receive_byte();
        logic [31:0] q;
        int          waits;
        q = '0;
        while (!q[ST_RX_HAS]) begin
            bus_access(STATUS_ADDR, 4'h0, 32'h0, q, waits);
        end
        if (exp_q.size() == 0) begin
            other_errors++;
            $display("a byte arrived at time %0t with none outstanding", $time);
        end else begin
            exp_on   = 1'b1;
            exp_data = {24'h0, exp_q.pop_front()};
            exp_mask = '1;
            bus_access(UART_BASE, 4'h0, 32'h0, q, waits);
        end
    endtask

    task automatic apply_step(input step_t s);
        logic [31:0] q;
        logic [7:0]  b;
        int          waits;
        int          stalls;
        stalls = 0;
        exp_on = 1'b0;
        case (s.op)
            OP_PINS: begin
                exp_pins = s.exp[2:0];
                pin_mask = s.mask[2:0];
                pin_on   = 1'b1;
                @(negedge clk);
                pin_on   = 1'b0;
            end
            OP_READ: begin
                exp_on   = 1'b1;
                exp_data = s.exp;
                exp_mask = s.mask;
                bus_access(s.addr, 4'h0, 32'h0, q, waits);
            end
            OP_WRITE: bus_access(s.addr, 4'hf, s.wdat, q, waits);
            OP_LOOP: loopback = s.wdat[0];
            OP_ECHO, OP_BURST: begin
                repeat (s.wdat) begin
                    take_byte(b);
                    exp_q.push_back(b);
                    bus_access(UART_BASE, 4'hf, {24'h0, b}, q, waits);
                    // More than one wait means the write was held off.
                    if (waits > 1) begin
                        stalls++;
                    end
                    if (s.op == OP_ECHO) begin
                        receive_byte();
                    end
                end
                if (s.op == OP_BURST && stalls == 0) begin
                    other_errors++;
                    $display("no DATA write was held off by the full TX FIFO");
                end
            end
            OP_RECV: repeat (s.wdat) receive_byte();
            OP_FRAME: begin
                take_byte(b);
                // Only a high stop bit delivers the byte.
                if (s.wdat[0]) begin
                    exp_q.push_back(b);
                end
                drive_frame(b, s.wdat[0]);
            end
            default: begin
                other_errors++;
                $display("step table holds an unknown operation %0d", s.op);
            end
        endcase
    endtask

    initial begin
        rst          = 1'b1;
        addr         = '0;
        we           = 4'h0;
        re           = 1'b0;
        wdata        = '0;
        tb_rxd       = 1'b1;
        loopback     = 1'b0;
        exp_on       = 1'b0;
        exp_data     = '0;
        exp_mask     = '0;
        pin_on       = 1'b0;
        exp_pins     = '0;
        pin_mask     = '0;
        other_errors = 0;
        lfsr         = 16'd17653;
        // Op, address, write data or count, expected read, compare mask.
        steps[0]  = '{OP_PINS, '0, 32'h0, 32'h6, 32'h7};
        steps[1]  = '{OP_READ, STATUS_ADDR, 32'h0, ROOM, '1};
        steps[2]  = '{OP_READ, DIVIDER_ADDR, 32'h0, {16'h0, INIT_DIV}, '1};
        steps[3]  = '{OP_WRITE, DIVIDER_ADDR, 32'(TB_DIV), 32'h0, 32'h0};
        steps[4]  = '{OP_READ, DIVIDER_ADDR, 32'h0, 32'(TB_DIV), '1};
        steps[5]  = '{OP_LOOP, '0, 32'h1, 32'h0, 32'h0};
        steps[6]  = '{OP_ECHO, '0, 32'd8, 32'h0, 32'h0};
        steps[7]  = '{OP_BURST, '0, 32'(TX_DEPTH + 2), 32'h0, 32'h0};
        // TX FIFO refilled by the stalled write.
        steps[8]  = '{OP_READ, STATUS_ADDR, 32'h0, 32'h0, 32'h1 << ST_TX_ROOM};
        // TX FIFO still holds bytes, so tx_empty is low.
        steps[9]  = '{OP_PINS, '0, 32'h0, 32'h0, 32'h2};
        steps[10] = '{OP_RECV, '0, 32'(TX_DEPTH + 2), 32'h0, 32'h0};
        steps[11] = '{OP_LOOP, '0, 32'h0, 32'h0, 32'h0};
        steps[12] = '{OP_FRAME, '0, 32'h1, 32'h0, 32'h0};
        // Good frame waits in the RX FIFO.
        steps[13] = '{OP_PINS, '0, 32'h0, 32'h7, 32'h7};
        steps[14] = '{OP_RECV, '0, 32'h1, 32'h0, 32'h0};
        steps[15] = '{OP_FRAME, '0, 32'h0, 32'h0, 32'h0};
        steps[16] = '{OP_READ, STATUS_ADDR, 32'h0, 32'h0, 32'h1 << ST_RX_HAS};
        // Empty RX FIFO reads zero.
        steps[17] = '{OP_READ, UART_BASE, 32'h0, 32'h0, '1};
        steps[18] = '{OP_READ, UART_BASE + 30'd3, 32'h0, 32'h0, '1};
        steps[19] = '{OP_PINS, '0, 32'h0, 32'h6, 32'h7};
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        repeat (4) @(negedge clk);
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, errors, other_errors);
        if (checks > 0 && errors == 0 && other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles without finishing", cycles);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/uart_checker.sv ====
// Compares on rising edges only; an expected word must hold until the cycle after ready.
`default_nettype none

module uart_checker (
    // Bus clock.
    input  wire         clk,
    // Synchronous reset.
    input  wire         rst,
    // Bus response from the DUT.
    input  wire         ready,
    input  wire  [31:0] rdata,
    // Pins from the DUT.
    input  wire         txd,
    input  wire         tx_empty,
    input  wire         rx_full,
    // Expected read word and the bits that count.
    input  wire         exp_on,
    input  wire  [31:0] exp_data,
    input  wire  [31:0] exp_mask,
    // Expected {txd, tx_empty, rx_full} and the pins that count.
    input  wire         pin_on,
    input  wire  [2:0]  exp_pins,
    input  wire  [2:0]  pin_mask,
    // Totals for the closing line.
    output int          checks,
    output int          errors
);

    always @(posedge clk) begin
        if (rst) begin
            checks = 0;
            errors = 0;
        end else begin
            // Ready is registered, so it is never unknown after reset.
            if ($isunknown(ready)) begin
                errors++;
                $display("ready is unknown at time %0t", $time);
            end
            // One compare per response.
            if (ready && exp_on) begin
                checks++;
                if ((rdata & exp_mask) !== (exp_data & exp_mask)) begin
                    errors++;
                    $display("FAIL %0t: read %h, expected %h under mask %h",
                             $time, rdata, exp_data, exp_mask);
                end
            end
            // Pin levels.
            if (pin_on) begin
                checks++;
                if (({txd, tx_empty, rx_full} & pin_mask) !== (exp_pins & pin_mask)) begin
                    errors++;
                    $display("FAIL %0t: txd/tx_empty/rx_full are %b, expected %b under mask %b",
                             $time, {txd, tx_empty, rx_full}, exp_pins, pin_mask);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/uart_periph.sv ====
// Responses take two cycles per access; a DATA write pushes byte lane 0 and DIVIDER writes need all strobes.
`default_nettype none

module uart_periph import uart_pkg::*; (
    // Bus clock.
    input  wire               clk,
    // Synchronous reset.
    input  wire               rst,
    // Word address.
    input  wire  [BUS_AW-1:0] addr,
    // Byte write strobes.
    input  wire  [3:0]        we,
    // Read request.
    input  wire               re,
    // Write data.
    input  wire  [31:0]       wdata,
    // Read data, valid with ready.
    output logic [31:0]       rdata,
    // Access done.
    output logic              ready,
    // Serial pins.
    output logic              txd,
    input  wire               rxd,
    // TX FIFO drained.
    output logic              tx_empty,
    // RX FIFO holds data.
    output logic              rx_full
);
    // Register decode.
    logic             sel_data;
    logic             sel_stat;
    logic             sel_div;
    logic             req;
    logic             data_wr;
    logic             stall;
    logic             accept;
    // Divider register.
    logic [DIV_W-1:0] clk_div;
    // TX side.
    logic             tx_push;
    logic             tx_trig;
    logic             tx_ack;
    logic             tx_busy;
    logic [7:0]       tx_head;
    logic             tx_has;
    logic             tx_full;
    // RX side.
    logic             rx_pop;
    logic             rx_trig;
    logic             rx_busy;
    logic [7:0]       rx_byte;
    logic [7:0]       rx_head;
    logic             rx_has;
    logic             rx_fifo_full;
    // Response mux.
    logic [31:0]      status;
    logic [31:0]      rd_word;

    assign sel_data = addr == UART_BASE;
    assign sel_stat = addr == STATUS_ADDR;
    assign sel_div  = addr == DIVIDER_ADDR;
    assign req      = re || (we != 4'b0000);
    assign data_wr  = sel_data && we[0];
    // Full TX FIFO holds the write off.
    assign stall    = TX_FULL_STALL && data_wr && tx_full;
    // Skip the cycle where ready is up so a held request is not taken twice.
    assign accept   = req && !ready && !stall;
    assign tx_push  = accept && data_wr && !tx_full;
    // Empty FIFO pops nothing.
    assign rx_pop   = accept && sel_data && re && rx_has;
    assign tx_trig  = tx_has && !tx_ack;

    // Interrupt levels.
    assign tx_empty = !tx_has;
    assign rx_full  = rx_has;

    always_ff @(posedge clk) begin
        if (rst) begin
            clk_div <= INIT_DIV;
        end else if (accept && sel_div && we == 4'b1111) begin
            clk_div <= wdata[DIV_W-1:0];
        end
    end

    always_comb begin
        status             = '0;
        status[ST_TX_BUSY] = tx_busy;
        status[ST_TX_HAS]  = tx_has;
        status[ST_TX_ROOM] = !tx_full;
        status[ST_RX_BUSY] = rx_busy;
        status[ST_RX_HAS]  = rx_has;
        status[ST_RX_ROOM] = !rx_fifo_full;
    end

    always_comb begin
        // Unmapped words read zero.
        rd_word = '0;
        if (sel_data && rx_has) begin
            rd_word = {24'h0, rx_head};
        end else if (sel_stat) begin
            rd_word = status;
        end else if (sel_div) begin
            rd_word = {{(32 - DIV_W){1'b0}}, clk_div};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready <= 1'b0;
        end else begin
            ready <= accept;
        end
    end

    // Data captured with the pop.
    always_ff @(posedge clk) begin
        if (accept) begin
            rdata <= rd_word;
        end
    end

    byte_fifo #(.depth(TX_DEPTH)) tx_fifo (
        .clk(clk), .rst(rst), .push(tx_push), .push_data(wdata[7:0]),
        .pop(tx_ack), .head(tx_head), .not_empty(tx_has), .full(tx_full)
    );

    uart_tx tx_phy (
        .clk(clk), .rst(rst), .clk_div(clk_div), .tx_byte(tx_head),
        .tx_trig(tx_trig), .tx_ack(tx_ack), .txd(txd), .tx_busy(tx_busy)
    );

    // Bytes arriving on a full FIFO are lost.
    byte_fifo #(.depth(RX_DEPTH)) rx_fifo (
        .clk(clk), .rst(rst), .push(rx_trig), .push_data(rx_byte),
        .pop(rx_pop), .head(rx_head), .not_empty(rx_has), .full(rx_fifo_full)
    );

    uart_rx rx_phy (
        .clk(clk), .rst(rst), .clk_div(clk_div), .rxd(rxd),
        .rx_byte(rx_byte), .rx_trig(rx_trig), .rx_busy(rx_busy)
    );

    // Each load pops the TX FIFO once.
    a_ack_once: assert property (@(posedge clk) disable iff (rst) tx_ack |=> !tx_ack);

endmodule

`default_nettype wire

// ==== rtl/uart_rx.sv ====
// 8N1 only; framing errors drop the byte without report, and rxd passes a two-flop synchronizer.
`default_nettype none

module uart_rx import uart_pkg::*; (
    // Undivided clock.
    input  wire              clk,
    // Synchronous reset.
    input  wire              rst,
    // Clock cycles per bit.
    input  wire [DIV_W-1:0]  clk_div,
    // Serial input.
    input  wire              rxd,
    // Last good byte.
    output logic [7:0]       rx_byte,
    // One-cycle strobe for rx_byte.
    output logic             rx_trig,
    // Frame in progress.
    output logic             rx_busy
);
    // Pin synchronizer.
    logic             rxd_meta;
    logic             rxd_sync;
    // Bit timer, counts down to one.
    logic [DIV_W-1:0] timer;
    // Reload values with zero mapped to one.
    logic [DIV_W-1:0] full_div;
    logic [DIV_W-1:0] half_div;
    // 0 idle, 1 start, 2 to 9 data, 10 stop.
    logic [3:0]       state;
    // Data shifts in from the top.
    logic [7:0]       rx_buf;

    assign full_div = (clk_div != '0) ? clk_div : DIV_W'(1);
    assign half_div = ((clk_div >> 1) != '0) ? (clk_div >> 1) : DIV_W'(1);
    assign rx_busy  = state != 4'd0;

    // Line idles high.
    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            timer   <= DIV_W'(1);
            state   <= 4'd0;
            rx_trig <= 1'b0;
        end else begin
            rx_trig <= 1'b0;
            if (state == 4'd0) begin
                if (!rxd_sync) begin
                    // Falling edge, aim for mid start bit.
                    state <= 4'd1;
                    timer <= half_div;
                end
            end else if (timer == DIV_W'(1)) begin
                timer <= full_div;
                if (state == 4'd1) begin
                    // Start bit must still be low at its middle.
                    state <= rxd_sync ? 4'd0 : 4'd2;
                end else if (state == 4'd10) begin
                    // Stop bit check.
                    state <= 4'd0;
                    if (rxd_sync) begin
                        rx_byte <= rx_buf;
                        rx_trig <= 1'b1;
                    end
                end else begin
                    // Data bits LSB first.
                    rx_buf <= {rxd_sync, rx_buf[7:1]};
                    state  <= state + 4'd1;
                end
            end else begin
                timer <= timer - DIV_W'(1);
            end
        end
    end

    // One push per frame.
    a_trig_pulse: assert property (@(posedge clk) disable iff (rst) rx_trig |=> !rx_trig);

endmodule

`default_nettype wire

// ==== rtl/uart_tx.sv ====
// 8N1 only; a divider of zero acts as one, and a frame starts on the next free-running bit tick.
`default_nettype none

module uart_tx import uart_pkg::*; (
    // Undivided clock.
    input  wire              clk,
    // Synchronous reset.
    input  wire              rst,
    // Clock cycles per bit.
    input  wire [DIV_W-1:0]  clk_div,
    // Byte to send.
    input  wire [7:0]        tx_byte,
    // Send request.
    input  wire              tx_trig,
    // Byte taken.
    output logic             tx_ack,
    // Serial output.
    output logic             txd,
    // Frame in progress.
    output logic             tx_busy
);
    // Bit timer, counts down to one.
    logic [DIV_W-1:0] timer;
    // Reload value with zero mapped to one.
    logic [DIV_W-1:0] full_div;
    // Bit counter, 0 is idle.
    logic [3:0]       state;
    // Start bit plus data bits.
    // LSB drives the line.
    logic [8:0]       tx_buf;

    assign full_div = (clk_div != '0) ? clk_div : DIV_W'(1);
    assign txd      = tx_buf[0];
    assign tx_busy  = state != 4'd0;

    always_ff @(posedge clk) begin
        if (rst) begin
            timer  <= DIV_W'(1);
            state  <= 4'd0;
            tx_buf <= 9'h1ff;
            tx_ack <= 1'b0;
        end else begin
            // Ack holds only while the trigger does.
            tx_ack <= tx_ack && tx_trig;
            if (timer == DIV_W'(1)) begin
                // Bit boundary.
                timer <= full_div;
                if (state == 4'd0) begin
                    if (tx_trig) begin
                        // Load byte behind a low start bit.
                        tx_buf <= {tx_byte, 1'b0};
                        state  <= 4'd1;
                        tx_ack <= 1'b1;
                    end
                end else begin
                    // Shift out LSB first.
                    // Ones fill from the top so the stop bit and idle are high.
                    tx_buf <= {1'b1, tx_buf[8:1]};
                    state  <= (state == 4'd9) ? 4'd0 : state + 4'd1;
                end
            end else begin
                timer <= timer - DIV_W'(1);
            end
        end
    end

    // Start bit plus eight data bits.
    a_state_range: assert property (@(posedge clk) disable iff (rst) state <= 4'd9);

endmodule

`default_nettype wire

// ==== rtl/byte_fifo.sv ====
// Depth must be a power of two of at least 4; push on full and pop on empty are ignored.
`default_nettype none

module byte_fifo #(
    // Entries, power of two.
    parameter int depth = 4
) (
    // Clock.
    input  wire         clk,
    // Synchronous reset.
    input  wire         rst,
    // Write strobe.
    input  wire         push,
    // Write byte.
    input  wire  [7:0]  push_data,
    // Read strobe.
    input  wire         pop,
    // Oldest entry, shown ahead.
    output logic [7:0]  head,
    // At least one entry.
    output logic        not_empty,
    // No room left.
    output logic        full
);
    localparam int AW = $clog2(depth);

    // Storage.
    logic [7:0]  mem [depth];
    // Pointers carry a wrap bit above the index.
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    // Qualified strobes.
    logic        do_push;
    logic        do_pop;

    assign not_empty = wr_ptr != rd_ptr;
    // Same index, opposite wrap bit.
    assign full      = (wr_ptr ^ rd_ptr) == {1'b1, {AW{1'b0}}};
    assign head      = mem[rd_ptr[AW-1:0]];
    assign do_push   = push && !full;
    assign do_pop    = pop && not_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Memory write.
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_data;
        end
    end

    // Callers must gate pops.
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> not_empty);

endmodule

`default_nettype wire

// ==== rtl/uart_pkg.sv ====
// Register map and sizing for the UART peripheral; FIFO depths must be powers of two of at least 4.
`default_nettype none

package uart_pkg;

    // Width of the word address on the peripheral bus.
    localparam int BUS_AW = 30;

    // Width of the clock divider register.
    localparam int DIV_W = 16;

    // Word address of DATA.
    localparam logic [BUS_AW-1:0] UART_BASE = 30'h2000_0000;
    // STATUS follows DATA.
    localparam logic [BUS_AW-1:0] STATUS_ADDR = UART_BASE + 30'd1;
    // DIVIDER follows STATUS.
    localparam logic [BUS_AW-1:0] DIVIDER_ADDR = UART_BASE + 30'd2;

    // Divider after reset.
    localparam logic [DIV_W-1:0] INIT_DIV = 16'd1250;

    // FIFO depths in bytes.
    localparam int TX_DEPTH = 4;
    localparam int RX_DEPTH = 4;

    // Stall DATA writes on a full TX FIFO instead of dropping them.
    localparam bit TX_FULL_STALL = 1'b1;

    // STATUS bit positions.
    // Transmit side sits in the low half.
    localparam int ST_TX_BUSY = 0;
    localparam int ST_TX_HAS  = 1;
    localparam int ST_TX_ROOM = 2;
    // Receive side sits in the high half.
    localparam int ST_RX_BUSY = 16;
    localparam int ST_RX_HAS  = 17;
    localparam int ST_RX_ROOM = 18;

endpackage

`default_nettype wire
